// File: ppu_register_block.f
hdl/ppu_regs_pkg.sv
hdl/ppu_frame_sequencer.sv
hdl/ppu_status_latch.sv
hdl/ppu_cpu_port.sv
hdl/ppu_register_block.sv
testbench/ppu_register_block_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the register block testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=ppu_register_block_tb
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" --Mdir "$BUILD_DIR" \
	-f ppu_register_block.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

OUTPUT=$("./$BUILD_DIR/V$TOP")
STATUS=$?
printf '%s\n' "$OUTPUT"

if [ $STATUS -ne 0 ]; then
	echo "simulation exited with status $STATUS"
	exit 1
fi

# pass only when the testbench printed its pass line
if printf '%s\n' "$OUTPUT" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: testbench/ppu_register_block_tb.sv
`timescale 1ns/1ps

module ppu_register_block_tb;
	import ppu_regs_pkg::*;

	// small frame so many frames fit in one run
	localparam int LINE_CYCLES = 8;
	localparam int VISIBLE_LINES = 3;
	localparam int FRAME_LINES = 5;
	localparam int SPRITE0_TIMEOUT = 20;
	localparam int RENDER_LEN = VISIBLE_LINES * LINE_CYCLES;
	localparam int FRAME_LEN = FRAME_LINES * LINE_CYCLES;

	logic clk;
	logic rst;
	logic [15:0] cpu_addr;
	logic cpu_read;
	logic cpu_write;
	logic [7:0] cpu_wdata;
	logic [7:0] cpu_rdata;
	logic sprite_0_hit;
	logic sprite_overflow;
	logic vga_done;
	logic [7:0] ppu_ctrl;
	logic [7:0] ppu_mask;
	logic [7:0] ppu_state;
	logic nmi;

	// model state with the frame position counted from the restart slot
	bit m_started;
	int m_pos;
	logic m_vb, m_s0, m_ov, m_arm;
	int m_cnt;
	logic [7:0] m_dly;
	ppu_status_u m_status;
	logic [7:0] m_ctrl, m_mask, m_bus, m_rdata;
	bit m_stat_rd;
	// which clear paths were hit
	int vb_by_read, vb_by_restart, s0_by_done, s0_by_timeout;
	int value_errs, other_errs;
	// cycles left in the current vga_done stretch
	int done_left;

	ppu_register_block #(
		.LINE_CYCLES(LINE_CYCLES),
		.VISIBLE_LINES(VISIBLE_LINES),
		.FRAME_LINES(FRAME_LINES),
		.SPRITE0_TIMEOUT(SPRITE0_TIMEOUT)
	) UUT (
		.clk(clk),
		.rst(rst),
		.cpu_addr(cpu_addr),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata),
		.sprite_0_hit(sprite_0_hit),
		.sprite_overflow(sprite_overflow),
		.vga_done(vga_done),
		.ppu_ctrl(ppu_ctrl),
		.ppu_mask(ppu_mask),
		.ppu_state(ppu_state),
		.nmi(nmi)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s got %02h expected %02h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
			value_errs++;
		end
	endtask

	// compared flag by flag so a bad byte names the flag
	task automatic check_status(input ppu_status_u got, input ppu_status_u exp);
		check_bit("status.vblank", got.flags.vblank, exp.flags.vblank);
		check_bit("status.sprite_0_hit", got.flags.sprite_0_hit, exp.flags.sprite_0_hit);
		check_bit("status.sprite_overflow", got.flags.sprite_overflow,
			exp.flags.sprite_overflow);
		check_byte("status.unused", {3'b000, got.flags.unused}, {3'b000, exp.flags.unused});
	endtask

	// state code for a frame position
	function automatic logic [7:0] state_at(input bit started, input int pos);
		if (!started)
			return ST_IDLE;
		if (pos == 0)
			return ST_RESTART;
		if (pos <= RENDER_LEN)
			return ST_RENDER;
		if (pos == RENDER_LEN + 1)
			return ST_VSYNC;
		return ST_VGA_WAIT;
	endfunction

	// one clock edge of the model using the inputs held before the edge
	task automatic model_step();
		logic [7:0] cur;
		logic in_win;
		ppu_status_u flags_now;
		cur = state_at(m_started, m_pos);
		in_win = (cpu_addr[15:13] == 3'b001);
		m_stat_rd = cpu_read && in_win && (cpu_addr[2:0] == REG_STATUS);
		flags_now.raw = 8'h00;
		flags_now.flags.vblank = m_vb;
		flags_now.flags.sprite_0_hit = m_s0;
		flags_now.flags.sprite_overflow = m_ov;
		// cpu side sees the status byte from before this edge
		if (cpu_read && in_win)
			m_rdata = (cpu_addr[2:0] == REG_STATUS) ? m_status.raw : m_bus;
		if (cpu_write && in_win) begin
			m_bus = cpu_wdata;
			if (cpu_addr[2:0] == REG_CTRL)
				m_ctrl = cpu_wdata;
			if (cpu_addr[2:0] == REG_MASK)
				m_mask = cpu_wdata;
		end
		// two register delay
		m_status.raw = m_dly;
		m_dly = flags_now.raw;
		if (!m_vb) begin
			m_vb = (cur == ST_VSYNC);
		end else if (cur == ST_RESTART) begin
			m_vb = 1'b0;
			vb_by_restart++;
		end else if (m_stat_rd) begin
			m_vb = 1'b0;
			vb_by_read++;
		end
		if (!m_ov)
			m_ov = sprite_overflow;
		else if (cur == ST_RESTART)
			m_ov = 1'b0;
		// sprite 0 arms on the first wait slot and then counts
		if (!m_s0) begin
			m_s0 = sprite_0_hit;
		end else if (!m_arm) begin
			if (cur == ST_VGA_WAIT) begin
				m_arm = 1'b1;
				m_cnt = 0;
			end
		end else begin
			if (!vga_done || m_cnt > SPRITE0_TIMEOUT) begin
				if (!vga_done)
					s0_by_done++;
				else
					s0_by_timeout++;
				m_s0 = 1'b0;
				m_arm = 1'b0;
			end
			m_cnt = m_cnt + 1;
		end
		if (!m_started) begin
			m_started = 1'b1;
			m_pos = 0;
		end else begin
			m_pos = (m_pos + 1) % FRAME_LEN;
		end
	endtask

	// steps the model on each edge and compares before the drive point
	task automatic step_cycle();
		ppu_status_u got_s;
		ppu_status_u exp_s;
		@(posedge clk);
		#1;
		model_step();
		check_byte("cpu_rdata", cpu_rdata, m_rdata);
		check_byte("ppu_ctrl", ppu_ctrl, m_ctrl);
		check_byte("ppu_mask", ppu_mask, m_mask);
		check_byte("ppu_state", ppu_state, state_at(m_started, m_pos));
		check_bit("nmi", nmi, m_status.flags.vblank & m_ctrl[7]);
		if (m_stat_rd) begin
			got_s.raw = cpu_rdata;
			exp_s.raw = m_rdata;
			check_status(got_s, exp_s);
		end
		#1;
	endtask

	task automatic drive_access(input logic rd, input logic wr, input logic [15:0] addr,
		input logic [7:0] data);
		cpu_read = rd;
		cpu_write = wr;
		cpu_addr = addr;
		cpu_wdata = data;
		sprite_0_hit = 1'b0;
		sprite_overflow = 1'b0;
		vga_done = 1'b1;
	endtask

	task automatic drive_random();
		int op;
		logic [2:0] off;
		logic [15:0] addr;
		op = $urandom % 3;
		addr = 16'($urandom);
		if ($urandom % 2 == 0) begin
			// status offset is favoured and the upper bits pick the mirror
			off = ($urandom % 4 == 0) ? REG_STATUS : 3'($urandom);
			addr = {3'b001, addr[12:3], off};
		end else if (addr[15:13] == 3'b001) begin
			addr[15] = 1'b1;
		end
		cpu_addr = addr;
		cpu_read = (op == 0);
		cpu_write = (op == 1);
		cpu_wdata = 8'($urandom);
		sprite_0_hit = ($urandom % 16 == 0);
		sprite_overflow = ($urandom % 24 == 0);
		// long high stretches let the timeout path win now and then
		if (done_left == 0) begin
			vga_done = !vga_done;
			done_left = vga_done ? 10 + $urandom % 50 : 1 + $urandom % 4;
		end else begin
			done_left--;
		end
	endtask

	task automatic wait_state(input logic [7:0] code, input int limit);
		int n;
		n = 0;
		while (ppu_state != code && n < limit) begin
			step_cycle();
			drive_access(1'b0, 1'b0, 16'h0000, 8'h00);
			n++;
		end
		if (ppu_state != code) begin
			$display("timeout: state code %0d not reached within %0d cycles", code, limit);
			other_errs++;
		end
	endtask

	initial begin
		void'($urandom(64290));
		rst = 1'b0;
		drive_access(1'b0, 1'b0, 16'h0000, 8'h00);
		done_left = 20;
		{m_started, m_vb, m_s0, m_ov, m_arm, m_stat_rd} = '0;
		{m_pos, m_cnt, value_errs, other_errs} = '0;
		{vb_by_read, vb_by_restart, s0_by_done, s0_by_timeout} = '0;
		{m_dly, m_status, m_ctrl, m_mask, m_bus, m_rdata} = '0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b1;
		// outputs straight out of reset
		check_byte("cpu_rdata", cpu_rdata, 8'h00);
		check_byte("ppu_ctrl", ppu_ctrl, 8'h00);
		check_byte("ppu_mask", ppu_mask, 8'h00);
		check_byte("ppu_state", ppu_state, ST_IDLE);
		check_bit("nmi", nmi, 1'b0);
		repeat (3000) begin
			step_cycle();
			drive_random();
		end
		// mirrored ctrl and mask writes with nmi enabled
		drive_access(1'b0, 1'b1, 16'h3ff8, 8'h80);
		step_cycle();
		check_byte("ppu_ctrl", ppu_ctrl, 8'h80);
		drive_access(1'b0, 1'b1, 16'h2b01, 8'h5a);
		step_cycle();
		check_byte("ppu_mask", ppu_mask, 8'h5a);
		// ctrl offset reads back the open bus
		drive_access(1'b1, 1'b0, 16'h2000, 8'h00);
		step_cycle();
		check_byte("cpu_rdata", cpu_rdata, 8'h5a);
		// writes outside the window are ignored
		drive_access(1'b0, 1'b1, 16'h4000, 8'hff);
		step_cycle();
		check_byte("ppu_ctrl", ppu_ctrl, 8'h80);
		drive_access(1'b0, 1'b0, 16'h0000, 8'h00);
		wait_state(ST_VSYNC, FRAME_LEN + 4);
		repeat (3) step_cycle();
		check_bit("nmi", nmi, 1'b1);
		// first read sees vblank and a later one sees it cleared
		drive_access(1'b1, 1'b0, 16'h3a0a, 8'h00);
		step_cycle();
		check_bit("cpu_rdata.vblank", cpu_rdata[7], 1'b1);
		drive_access(1'b0, 1'b0, 16'h0000, 8'h00);
		repeat (3) step_cycle();
		drive_access(1'b1, 1'b0, 16'h200a, 8'h00);
		step_cycle();
		check_bit("cpu_rdata.vblank", cpu_rdata[7], 1'b0);
		drive_access(1'b0, 1'b0, 16'h0000, 8'h00);
		// with no read this frame the restart drops it
		wait_state(ST_VSYNC, FRAME_LEN + 4);
		wait_state(ST_RESTART, FRAME_LEN + 4);
		repeat (3) step_cycle();
		check_bit("nmi", nmi, 1'b0);
		if (vb_by_read == 0 || vb_by_restart == 0) begin
			$display("vblank was not cleared both by a status read and by restart");
			other_errs++;
		end
		if (s0_by_done == 0 || s0_by_timeout == 0) begin
			$display("sprite 0 hit was not cleared both by vga_done and by the timeout");
			other_errs++;
		end
		$display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: hdl/ppu_register_block.sv
`timescale 1ns/1ps

module ppu_register_block #(
	parameter int LINE_CYCLES = 341,
	parameter int VISIBLE_LINES = 240,
	parameter int FRAME_LINES = 262,
	parameter int SPRITE0_TIMEOUT = 50000
) (
	input logic clk,
	input logic rst,
	input logic [15:0] cpu_addr,
	input logic cpu_read,
	input logic cpu_write,
	input logic [7:0] cpu_wdata,
	output logic [7:0] cpu_rdata,
	input logic sprite_0_hit,
	input logic sprite_overflow,
	input logic vga_done,
	output logic [7:0] ppu_ctrl,
	output logic [7:0] ppu_mask,
	output logic [7:0] ppu_state,
	output logic nmi
);
	import ppu_regs_pkg::*;

	// sequencer to latch
	logic vsync_pulse;
	// cpu port and latch
	logic status_read;
	ppu_status_u status_byte;

	ppu_frame_sequencer #(
		.LINE_CYCLES(LINE_CYCLES),
		.VISIBLE_LINES(VISIBLE_LINES),
		.FRAME_LINES(FRAME_LINES)
	) u_sequencer (
		.clk(clk),
		.rst(rst),
		.ppu_state(ppu_state),
		.vsync_pulse(vsync_pulse)
	);

	ppu_status_latch #(
		.SPRITE0_TIMEOUT(SPRITE0_TIMEOUT)
	) u_status (
		.clk(clk),
		.rst(rst),
		.sprite_0_hit(sprite_0_hit),
		.sprite_overflow(sprite_overflow),
		.vsync_pulse(vsync_pulse),
		.ppu_state(ppu_state),
		.status_read(status_read),
		.vga_done(vga_done),
		.status_byte(status_byte)
	);

	ppu_cpu_port u_cpu_port (
		.clk(clk),
		.rst(rst),
		.cpu_addr(cpu_addr),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_wdata(cpu_wdata),
		.status_byte(status_byte),
		.status_read(status_read),
		.cpu_rdata(cpu_rdata),
		.ppu_ctrl(ppu_ctrl),
		.ppu_mask(ppu_mask),
		.nmi(nmi)
	);

endmodule

// File: hdl/ppu_cpu_port.sv
`timescale 1ns/1ps

module ppu_cpu_port (
	input logic clk,
	input logic rst,
	input logic [15:0] cpu_addr,
	input logic cpu_read,
	input logic cpu_write,
	input logic [7:0] cpu_wdata,
	input ppu_regs_pkg::ppu_status_u status_byte,
	output logic status_read,
	output logic [7:0] cpu_rdata,
	output logic [7:0] ppu_ctrl,
	output logic [7:0] ppu_mask,
	output logic nmi
);
	import ppu_regs_pkg::*;

	// top three address bits select the window
	localparam logic [15:0] WINDOW_MASK = 16'hE000;

	logic in_window;
	logic [2:0] reg_offset;
	logic win_read;
	logic win_write;
	// last byte written anywhere in the window
	logic [7:0] open_bus;

	// every 8 bytes mirror $2000-$2007
	assign in_window = ((cpu_addr & WINDOW_MASK) == REG_WINDOW_BASE);
	assign reg_offset = cpu_addr[2:0];
	assign win_read = cpu_read && in_window;
	assign win_write = cpu_write && in_window;

	// same cycle strobe, latch clears vblank on the following edge
	assign status_read = win_read && (reg_offset == REG_STATUS);

	// register writes
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_ctrl <= '0;
			ppu_mask <= '0;
			open_bus <= '0;
		end else if (win_write) begin
			open_bus <= cpu_wdata;
			case (reg_offset)
				REG_CTRL: ppu_ctrl <= cpu_wdata;
				REG_MASK: ppu_mask <= cpu_wdata;
				// $2002-$2007 take nothing but the bus byte
				default: ;
			endcase
		end
	end

	// read data, held between reads
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cpu_rdata <= '0;
		end else if (win_read) begin
			// status sampled before the read clears vblank
			if (reg_offset == REG_STATUS) begin
				cpu_rdata <= status_byte.raw;
			end else begin
				cpu_rdata <= open_bus;
			end
		end
	end

	// level request while vblank is up and ctrl bit 7 enables it
	assign nmi = status_byte.flags.vblank & ppu_ctrl[7];

	// cpu strobes are exclusive
	a_no_read_write: assert property (
		@(posedge clk) disable iff (!rst)
		!(cpu_read && cpu_write)
	);

endmodule

// File: hdl/ppu_status_latch.sv
`timescale 1ns/1ps

module ppu_status_latch #(
	parameter int SPRITE0_TIMEOUT = 50000
) (
	input logic clk,
	input logic rst,
	input logic sprite_0_hit,
	input logic sprite_overflow,
	input logic vsync_pulse,
	input logic [7:0] ppu_state,
	input logic status_read,
	input logic vga_done,
	output ppu_regs_pkg::ppu_status_u status_byte
);
	import ppu_regs_pkg::*;

	// counter must reach SPRITE0_TIMEOUT + 1
	localparam int TW = $clog2(SPRITE0_TIMEOUT + 2);
	localparam logic [TW-1:0] S0_LIMIT = TW'(SPRITE0_TIMEOUT);

	logic vblank_q;
	logic sprite0_q;
	logic overflow_q;
	// sprite 0 clear machine
	logic s0_armed;
	logic [TW-1:0] s0_cnt;
	// flags before the delay
	ppu_status_u status_now;
	logic [7:0] status_dly;

	// vblank, set by vsync, cleared by restart or a $2002 read
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vblank_q <= 1'b0;
		end else if (!vblank_q) begin
			if (vsync_pulse) begin
				vblank_q <= 1'b1;
			end
		end else if (ppu_state == ST_RESTART || status_read) begin
			vblank_q <= 1'b0;
		end
	end

	// overflow only drops at frame restart
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			overflow_q <= 1'b0;
		end else if (!overflow_q) begin
			if (sprite_overflow) begin
				overflow_q <= 1'b1;
			end
		end else if (ppu_state == ST_RESTART) begin
			overflow_q <= 1'b0;
		end
	end

	// sprite 0 hit
	// held until the video side finishes, or the timeout as a fallback
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sprite0_q <= 1'b0;
			s0_armed <= 1'b0;
			s0_cnt <= '0;
		end else if (!sprite0_q) begin
			if (sprite_0_hit) begin
				sprite0_q <= 1'b1;
			end
		end else if (!s0_armed) begin
			// first wait cycle arms the clear
			if (ppu_state == ST_VGA_WAIT) begin
				s0_armed <= 1'b1;
				s0_cnt <= '0;
			end
		end else begin
			s0_cnt <= s0_cnt + 1'b1;
			if (s0_cnt > S0_LIMIT || !vga_done) begin
				sprite0_q <= 1'b0;
				s0_armed <= 1'b0;
			end
		end
	end

	always_comb begin
		status_now.flags.vblank = vblank_q;
		status_now.flags.sprite_0_hit = sprite0_q;
		status_now.flags.sprite_overflow = overflow_q;
		status_now.flags.unused = '0;
	end

	// two stage delay to the cpu side
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			status_dly <= '0;
			status_byte.raw <= '0;
		end else begin
			status_dly <= status_now.raw;
			status_byte.raw <= status_dly;
		end
	end

	// low bits stay clear through the delay line
	a_unused_zero: assert property (
		@(posedge clk) disable iff (!rst)
		status_byte.flags.unused == '0
	);

	// the clear counter only runs under a set flag
	a_s0_count_needs_flag: assert property (
		@(posedge clk) disable iff (!rst)
		s0_armed |-> sprite0_q
	);

endmodule

// File: hdl/ppu_frame_sequencer.sv
`timescale 1ns/1ps

module ppu_frame_sequencer #(
	parameter int LINE_CYCLES = 341,
	parameter int VISIBLE_LINES = 240,
	parameter int FRAME_LINES = 262
) (
	input logic clk,
	input logic rst,
	output logic [7:0] ppu_state,
	output logic vsync_pulse
);
	import ppu_regs_pkg::*;

	localparam int CW = (LINE_CYCLES > 1) ? $clog2(LINE_CYCLES) : 1;
	localparam int LW = (FRAME_LINES > 1) ? $clog2(FRAME_LINES) : 1;
	// last cycle of a line
	localparam logic [CW-1:0] CYC_LAST = CW'(LINE_CYCLES - 1);
	// restart and vsync each take one slot, so the wait ends two short
	localparam logic [CW-1:0] CYC_WAIT_END = CW'(LINE_CYCLES - 3);
	localparam logic [LW-1:0] LINE_RENDER_END = LW'(VISIBLE_LINES - 1);
	localparam logic [LW-1:0] LINE_FRAME_END = LW'(FRAME_LINES - 1);

	// position inside the frame
	logic [CW-1:0] cyc_cnt;
	logic [LW-1:0] line_cnt;
	// counters advanced by one slot
	logic [CW-1:0] cyc_next;
	logic [LW-1:0] line_next;
	logic line_wrap;

	assign line_wrap = (cyc_cnt == CYC_LAST);

	always_comb begin
		if (line_wrap) begin
			cyc_next = '0;
			line_next = line_cnt + 1'b1;
		end else begin
			cyc_next = cyc_cnt + 1'b1;
			line_next = line_cnt;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_state <= ST_IDLE;
			cyc_cnt <= '0;
			line_cnt <= '0;
		end else begin
			case (ppu_state)
				// single idle slot out of reset
				ST_IDLE: begin
					ppu_state <= ST_RESTART;
				end
				ST_RESTART: begin
					cyc_cnt <= '0;
					line_cnt <= '0;
					ppu_state <= ST_RENDER;
				end
				// visible lines, leaves on the wrap of the last one
				ST_RENDER: begin
					cyc_cnt <= cyc_next;
					line_cnt <= line_next;
					if (line_wrap && line_cnt == LINE_RENDER_END) begin
						ppu_state <= ST_VSYNC;
					end
				end
				// counters hold here at line VISIBLE_LINES, cycle 0
				ST_VSYNC: begin
					ppu_state <= ST_VGA_WAIT;
				end
				ST_VGA_WAIT: begin
					if (line_cnt == LINE_FRAME_END && cyc_cnt == CYC_WAIT_END) begin
						ppu_state <= ST_RESTART;
					end else begin
						cyc_cnt <= cyc_next;
						line_cnt <= line_next;
					end
				end
				// unknown code, start over
				default: begin
					ppu_state <= ST_IDLE;
				end
			endcase
		end
	end

	// one cycle wide, lines up with the vsync state
	assign vsync_pulse = (ppu_state == ST_VSYNC);

	// restart is a single slot per frame
	a_restart_one_cycle: assert property (
		@(posedge clk) disable iff (!rst)
		(ppu_state == ST_RESTART) |=> (ppu_state != ST_RESTART)
	);

endmodule

// File: hdl/ppu_regs_pkg.sv
package ppu_regs_pkg;

	// $2002 byte, bits 7..5 are the live flags
	typedef struct packed {
		logic vblank;
		logic sprite_0_hit;
		logic sprite_overflow;
		// reads back as zero
		logic [4:0] unused;
	} ppu_status_flags_t;

	// same byte, flag view inside the latch, raw view on the cpu bus
	typedef union packed {
		logic [7:0] raw;
		ppu_status_flags_t flags;
	} ppu_status_u;

	// frame sequencer state codes
	localparam logic [7:0] ST_IDLE = 8'd0;
	localparam logic [7:0] ST_RESTART = 8'd1;
	localparam logic [7:0] ST_RENDER = 8'd2;
	localparam logic [7:0] ST_VSYNC = 8'd4;
	// video out still busy with the frame
	localparam logic [7:0] ST_VGA_WAIT = 8'd8;

	// register offsets, addr[2:0] inside the window
	localparam logic [2:0] REG_CTRL = 3'd0;
	localparam logic [2:0] REG_MASK = 3'd1;
	localparam logic [2:0] REG_STATUS = 3'd2;

	// mirrored window $2000-$3fff
	localparam logic [15:0] REG_WINDOW_BASE = 16'h2000;

endpackage
